// File: design/fu_status_table.sv
`timescale 1ns/100ps

module fu_status_table import scoreboard_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  fu_id_t          dec_fu,
    input  op_code_t        dec_op,
    input  reg_idx_t        dec_dst,
    input  reg_idx_t        dec_src1,
    input  reg_idx_t        dec_src2,
    input  logic            jump_done,
    input  logic            is_jump,
    input  logic            alu_done,
    input  logic            mem_done,
    input  fu_id_t          ro_grant,
    input  fu_id_t          wb_grant,
    output logic            is_en,
    output logic            alu_rdy, mem_rdy, jump_rdy,
    output logic            alu_fin, mem_fin, jump_fin,
    output logic            alu_war_ok, mem_war_ok, jump_war_ok,
    output op_code_t        alu_code, mem_code, jump_code,
    output reg_idx_t        alu_dst, mem_dst, jump_dst,
    output reg_idx_t        alu_src1, mem_src1, jump_src1,
    output reg_idx_t        alu_src2, mem_src2, jump_src2,
    output logic [xlen-1:0] alu_pc, mem_pc, jump_pc,
    output logic [xlen-1:0] alu_imm, mem_imm, jump_imm
);

    logic            busy_q [1:3];
    logic            done_q [1:3];
    logic            rdy1_q [1:3];
    logic            rdy2_q [1:3];
    fu_id_t          fu1_q  [1:3];  // producer of src1, none once woken
    fu_id_t          fu2_q  [1:3];
    op_code_t        op_q   [1:3];
    reg_idx_t        dst_q  [1:3];
    reg_idx_t        src1_q [1:3];
    reg_idx_t        src2_q [1:3];
    logic [xlen-1:0] pc_q   [1:3];
    logic [xlen-1:0] imm_q  [1:3];
    logic            war    [1:3];
    fu_id_t          rrs    [num_regs];  // register result status
    logic            ctrl_stall;  // jump in flight
    logic            is_flush;
    logic            normal_stall;
    logic            ro_en;
    logic            issue;
    fu_id_t          fu1_new;
    fu_id_t          fu2_new;

    // structural hazard or waw
    always_comb begin
        normal_stall = (dec_fu != fu_none) && busy_q[dec_fu];
        for (int u = 1; u <= 3; u++) begin
            if (busy_q[u] && dec_dst != '0 && dst_q[u] == dec_dst) begin
                normal_stall = 1'b1;
            end
        end
    end

    assign is_en = is_flush | (~normal_stall & ~ctrl_stall);
    assign ro_en = ~is_flush & ~normal_stall & ~ctrl_stall;
    assign issue = ro_en && (dec_fu != fu_none);

    // a producer retiring this cycle is already ready for the new entry
    assign fu1_new = (rrs[dec_src1] == wb_grant) ? fu_none : rrs[dec_src1];
    assign fu2_new = (rrs[dec_src2] == wb_grant) ? fu_none : rrs[dec_src2];

    // war: no other unit still waits to read this unit's destination
    always_comb begin
        for (int u = 1; u <= 3; u++) begin
            war[u] = 1'b1;
            for (int v = 1; v <= 3; v++) begin
                if (v != u && dst_q[u] != '0) begin
                    if ((src1_q[v] == dst_q[u] && rdy1_q[v]) ||
                        (src2_q[v] == dst_q[u] && rdy2_q[v])) begin
                        war[u] = 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_stall <= 1'b0;
            is_flush   <= 1'b0;
        end else begin
            if (issue && dec_fu == fu_jump) begin
                ctrl_stall <= 1'b1;
            end else if (jump_done) begin
                ctrl_stall <= 1'b0;
            end
            is_flush <= jump_done & is_jump;  // drop the wrong-path slot
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int u = 1; u <= 3; u++) begin
                busy_q[u] <= 1'b0;
                done_q[u] <= 1'b0;
                rdy1_q[u] <= 1'b0;
                rdy2_q[u] <= 1'b0;
                fu1_q[u]  <= fu_none;
                fu2_q[u]  <= fu_none;
            end
            for (int r = 0; r < num_regs; r++) begin
                rrs[r] <= fu_none;
            end
        end else begin
            if (ro_grant != fu_none) begin  // operands read
                rdy1_q[ro_grant] <= 1'b0;
                rdy2_q[ro_grant] <= 1'b0;
            end
            if (alu_done) done_q[fu_alu] <= 1'b1;
            if (mem_done) done_q[fu_mem] <= 1'b1;
            if (jump_done) done_q[fu_jump] <= 1'b1;
            if (wb_grant != fu_none) begin
                busy_q[wb_grant]       <= 1'b0;
                done_q[wb_grant]       <= 1'b0;
                rrs[dst_q[wb_grant]]   <= fu_none;
                for (int u = 1; u <= 3; u++) begin  // raw wakeup
                    if (busy_q[u] && fu1_q[u] == wb_grant) begin
                        rdy1_q[u] <= 1'b1;
                        fu1_q[u]  <= fu_none;
                    end
                    if (busy_q[u] && fu2_q[u] == wb_grant) begin
                        rdy2_q[u] <= 1'b1;
                        fu2_q[u]  <= fu_none;
                    end
                end
            end
            if (issue) begin
                busy_q[dec_fu] <= 1'b1;
                done_q[dec_fu] <= 1'b0;
                fu1_q[dec_fu]  <= fu1_new;
                fu2_q[dec_fu]  <= fu2_new;
                rdy1_q[dec_fu] <= (fu1_new == fu_none);
                rdy2_q[dec_fu] <= (fu2_new == fu_none);
                if (dec_dst != '0) rrs[dec_dst] <= dec_fu;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_q[dec_fu]   <= dec_op;
            dst_q[dec_fu]  <= dec_dst;
            src1_q[dec_fu] <= dec_src1;
            src2_q[dec_fu] <= dec_src2;
            pc_q[dec_fu]   <= pc;
            imm_q[dec_fu]  <= imm;
        end
    end

    assign alu_rdy     = rdy1_q[fu_alu] & rdy2_q[fu_alu];
    assign mem_rdy     = rdy1_q[fu_mem] & rdy2_q[fu_mem];
    assign jump_rdy    = rdy1_q[fu_jump] & rdy2_q[fu_jump];
    assign alu_fin     = done_q[fu_alu];
    assign mem_fin     = done_q[fu_mem];
    assign jump_fin    = done_q[fu_jump];
    assign alu_war_ok  = war[fu_alu];
    assign mem_war_ok  = war[fu_mem];
    assign jump_war_ok = war[fu_jump];
    assign alu_code    = op_q[fu_alu];
    assign mem_code    = op_q[fu_mem];
    assign jump_code   = op_q[fu_jump];
    assign alu_dst     = dst_q[fu_alu];
    assign mem_dst     = dst_q[fu_mem];
    assign jump_dst    = dst_q[fu_jump];
    assign alu_src1    = src1_q[fu_alu];
    assign mem_src1    = src1_q[fu_mem];
    assign jump_src1   = src1_q[fu_jump];
    assign alu_src2    = src2_q[fu_alu];
    assign mem_src2    = src2_q[fu_mem];
    assign jump_src2   = src2_q[fu_jump];
    assign alu_pc      = pc_q[fu_alu];
    assign mem_pc      = pc_q[fu_mem];
    assign jump_pc     = pc_q[fu_jump];
    assign alu_imm     = imm_q[fu_alu];
    assign mem_imm     = imm_q[fu_mem];
    assign jump_imm    = imm_q[fu_jump];

endmodule

// File: design/grant_arbiter.sv
`timescale 1ns/100ps

module grant_arbiter import scoreboard_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic            alu_rdy, mem_rdy, jump_rdy,
    input  logic            alu_fin, mem_fin, jump_fin,
    input  logic            alu_war_ok, mem_war_ok, jump_war_ok,
    input  op_code_t        alu_code, mem_code, jump_code,
    input  reg_idx_t        alu_dst, mem_dst, jump_dst,
    input  reg_idx_t        alu_src1, mem_src1, jump_src1,
    input  reg_idx_t        alu_src2, mem_src2, jump_src2,
    input  logic [xlen-1:0] alu_pc, mem_pc, jump_pc,
    input  logic [xlen-1:0] alu_imm, mem_imm, jump_imm,
    output fu_id_t          ro_grant,
    output fu_id_t          wb_grant,
    output logic            alu_en,
    output logic            mem_en,
    output logic            jump_en,
    output reg_idx_t        rs1_ctrl,
    output reg_idx_t        rs2_ctrl,
    output logic [xlen-1:0] pc_ctrl,
    output logic [xlen-1:0] imm_ctrl,
    output op_code_t        jump_op,
    output alu_op_t         alu_op,
    output logic            alu_use_pc,
    output logic            alu_use_imm,
    output logic            mem_we,
    output mem_bhw_t        mem_bhw,
    output wb_sel_t         write_sel,
    output logic            reg_write,
    output reg_idx_t        rd_ctrl
);

    // read operands, jump first
    always_comb begin
        ro_grant    = fu_none;
        alu_en      = 1'b0;
        mem_en      = 1'b0;
        jump_en     = 1'b0;
        rs1_ctrl    = '0;
        rs2_ctrl    = '0;
        pc_ctrl     = '0;
        imm_ctrl    = '0;
        jump_op     = '0;
        alu_op      = '0;
        alu_use_pc  = 1'b0;
        alu_use_imm = 1'b0;
        mem_we      = 1'b0;
        mem_bhw     = '0;
        if (jump_rdy) begin
            ro_grant = fu_jump;
            jump_en  = 1'b1;
            jump_op  = jump_code;
            rs1_ctrl = jump_src1;
            rs2_ctrl = jump_src2;
            pc_ctrl  = jump_pc;
            imm_ctrl = jump_imm;
        end else if (alu_rdy) begin
            ro_grant    = fu_alu;
            alu_en      = 1'b1;
            alu_use_pc  = (alu_code == op_alu_auipc);
            alu_op      = alu_use_pc ? op_alu_add[3:0] : alu_code[3:0];  // auipc is pc + imm
            alu_use_imm = alu_code[4];
            rs1_ctrl    = alu_src1;
            rs2_ctrl    = alu_src2;
            pc_ctrl     = alu_pc;
            imm_ctrl    = alu_imm;
        end else if (mem_rdy) begin
            ro_grant = fu_mem;
            mem_en   = 1'b1;
            mem_we   = mem_code[0];
            mem_bhw  = mem_code[3:1];
            rs1_ctrl = mem_src1;
            rs2_ctrl = mem_src2;  // store data
            pc_ctrl  = mem_pc;
            imm_ctrl = mem_imm;
        end
    end

    // write-back, same order, each held back until war clears
    always_comb begin
        wb_grant  = fu_none;
        write_sel = wb_alu;
        reg_write = 1'b0;
        rd_ctrl   = '0;
        if (jump_fin && jump_war_ok) begin
            wb_grant  = fu_jump;
            write_sel = wb_jump;
            reg_write = (jump_dst != '0);  // branches free the entry only
            rd_ctrl   = jump_dst;
        end else if (alu_fin && alu_war_ok) begin
            wb_grant  = fu_alu;
            write_sel = wb_alu;
            reg_write = (alu_dst != '0);
            rd_ctrl   = alu_dst;
        end else if (mem_fin && mem_war_ok) begin
            wb_grant  = fu_mem;
            write_sel = wb_mem;
            reg_write = (mem_dst != '0);  // stores have no rd
            rd_ctrl   = mem_dst;
        end
    end

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import scoreboard_pkg::*; (
    input  logic [31:0] inst,
    output fu_id_t      dec_fu,
    output op_code_t    dec_op,
    output reg_idx_t    dec_dst,
    output reg_idx_t    dec_src1,
    output reg_idx_t    dec_src2,
    output imm_sel_t    imm_sel
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       r_ok;      // legal funct7 for a register form
    logic       shift_ok;  // legal funct7 for an immediate form
    op_code_t   r_op;
    op_code_t   b_op;
    logic       has_unit;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign r_ok = (funct7 == 7'h00) ||
                  (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
    assign shift_ok = (funct3 == 3'd1) ? (funct7 == 7'h00) :
                      (funct3 == 3'd5) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;

    always_comb begin
        case (funct3)
            3'd0:    r_op = (funct7[5] && opcode == opcode_op) ? op_alu_sub : op_alu_add;
            3'd1:    r_op = op_alu_sll;
            3'd2:    r_op = op_alu_slt;
            3'd3:    r_op = op_alu_sltu;
            3'd4:    r_op = op_alu_xor;
            3'd5:    r_op = funct7[5] ? op_alu_sra : op_alu_srl;
            3'd6:    r_op = op_alu_or;
            default: r_op = op_alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'd0:    b_op = op_jump_beq;
            3'd1:    b_op = op_jump_bne;
            3'd4:    b_op = op_jump_blt;
            3'd5:    b_op = op_jump_bge;
            3'd6:    b_op = op_jump_bltu;
            default: b_op = op_jump_bgeu;
        endcase
    end

    always_comb begin
        dec_fu  = fu_none;
        dec_op  = '0;
        imm_sel = '0;
        case (opcode)
            opcode_op: begin
                dec_fu = r_ok ? fu_alu : fu_none;
                dec_op = r_op;
            end
            opcode_op_imm: begin
                dec_fu  = shift_ok ? fu_alu : fu_none;
                dec_op  = r_op | op_alu_imm;
                imm_sel = imm_i;
            end
            opcode_lui, opcode_auipc: begin
                dec_fu  = fu_alu;
                dec_op  = (opcode == opcode_lui) ? op_alu_lui : op_alu_auipc;
                imm_sel = imm_u;
            end
            opcode_load: begin
                dec_fu  = (funct3 != 3'd3 && funct3 < 3'd6) ? fu_mem : fu_none;
                dec_op  = {1'b0, funct3, 1'b0};  // funct3 is the bhw kind
                imm_sel = imm_i;
            end
            opcode_store: begin
                dec_fu  = (funct3 < 3'd3) ? fu_mem : fu_none;
                dec_op  = {1'b0, funct3, 1'b1};
                imm_sel = imm_s;
            end
            opcode_branch: begin
                dec_fu  = (funct3 != 3'd2 && funct3 != 3'd3) ? fu_jump : fu_none;
                dec_op  = b_op;
                imm_sel = imm_b;
            end
            opcode_jal: begin
                dec_fu  = fu_jump;
                dec_op  = op_jump_jal;
                imm_sel = imm_j;
            end
            opcode_jalr: begin
                dec_fu  = (funct3 == 3'd0) ? fu_jump : fu_none;
                dec_op  = op_jump_jalr;
                imm_sel = imm_i;
            end
            default: ;
        endcase
    end

    // register fields follow from the immediate format; an r-type has none
    assign has_unit = (dec_fu != fu_none);
    assign dec_dst  = (has_unit && imm_sel != imm_s && imm_sel != imm_b) ? inst[11:7] : '0;
    assign dec_src1 = (has_unit && imm_sel != imm_u && imm_sel != imm_j) ? inst[19:15] : '0;
    assign dec_src2 = (has_unit && (imm_sel == '0 || imm_sel == imm_s || imm_sel == imm_b)) ?
                      inst[24:20] : '0;

endmodule

// File: design/scoreboard_ctrl.sv
`timescale 1ns/100ps

module scoreboard_ctrl import scoreboard_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] pc,
    input  logic [31:0]     inst,
    input  logic [xlen-1:0] imm,
    input  logic            alu_done,
    input  logic            mem_done,
    input  logic            jump_done,
    input  logic            is_jump,
    output logic            is_en,
    output imm_sel_t        imm_sel,
    output logic            alu_en,
    output logic            mem_en,
    output logic            jump_en,
    output reg_idx_t        rs1_ctrl,
    output reg_idx_t        rs2_ctrl,
    output logic [xlen-1:0] pc_ctrl,
    output logic [xlen-1:0] imm_ctrl,
    output op_code_t        jump_op,
    output alu_op_t         alu_op,
    output logic            alu_use_pc,
    output logic            alu_use_imm,
    output logic            mem_we,
    output mem_bhw_t        mem_bhw,
    output wb_sel_t         write_sel,
    output logic            reg_write,
    output reg_idx_t        rd_ctrl
);

    fu_id_t          dec_fu;
    op_code_t        dec_op;
    reg_idx_t        dec_dst;
    reg_idx_t        dec_src1;
    reg_idx_t        dec_src2;
    fu_id_t          ro_grant;  // one-cycle strobes back to the table
    fu_id_t          wb_grant;
    logic            alu_rdy, mem_rdy, jump_rdy;
    logic            alu_fin, mem_fin, jump_fin;
    logic            alu_war_ok, mem_war_ok, jump_war_ok;
    op_code_t        alu_code, mem_code, jump_code;
    reg_idx_t        alu_dst, mem_dst, jump_dst;
    reg_idx_t        alu_src1, mem_src1, jump_src1;
    reg_idx_t        alu_src2, mem_src2, jump_src2;
    logic [xlen-1:0] alu_pc, mem_pc, jump_pc;
    logic [xlen-1:0] alu_imm, mem_imm, jump_imm;

    // names line up across all three blocks
    inst_decoder dec0 (.*);

    fu_status_table #(
        .xlen(xlen)
    ) table0 (.*);

    grant_arbiter #(
        .xlen(xlen)
    ) arb0 (.*);

endmodule

// File: design/scoreboard_pkg.sv
package scoreboard_pkg;

    localparam int num_regs = 32;

    typedef logic [1:0] fu_id_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [4:0] op_code_t;
    typedef logic [2:0] imm_sel_t;
    typedef logic [2:0] wb_sel_t;
    typedef logic [3:0] alu_op_t;
    typedef logic [2:0] mem_bhw_t;

    localparam fu_id_t fu_none = 2'd0;
    localparam fu_id_t fu_alu  = 2'd1;
    localparam fu_id_t fu_mem  = 2'd2;
    localparam fu_id_t fu_jump = 2'd3;

    // alu codes, bit 4 set means second operand is the immediate
    localparam op_code_t op_alu_add   = 5'h01;
    localparam op_code_t op_alu_sub   = 5'h02;
    localparam op_code_t op_alu_and   = 5'h03;
    localparam op_code_t op_alu_or    = 5'h04;
    localparam op_code_t op_alu_xor   = 5'h05;
    localparam op_code_t op_alu_sll   = 5'h06;
    localparam op_code_t op_alu_srl   = 5'h07;
    localparam op_code_t op_alu_slt   = 5'h08;
    localparam op_code_t op_alu_sltu  = 5'h09;
    localparam op_code_t op_alu_sra   = 5'h0a;
    localparam op_code_t op_alu_lui   = 5'h1b;
    localparam op_code_t op_alu_auipc = 5'h1f;  // becomes an add on pc
    localparam op_code_t op_alu_imm   = 5'h10;  // or'd onto a register form

    // mem codes are {0, funct3, write}
    localparam op_code_t op_mem_lb  = 5'b0_000_0;
    localparam op_code_t op_mem_lh  = 5'b0_001_0;
    localparam op_code_t op_mem_lw  = 5'b0_010_0;
    localparam op_code_t op_mem_lbu = 5'b0_100_0;
    localparam op_code_t op_mem_lhu = 5'b0_101_0;
    localparam op_code_t op_mem_sb  = 5'b0_000_1;
    localparam op_code_t op_mem_sh  = 5'b0_001_1;
    localparam op_code_t op_mem_sw  = 5'b0_010_1;

    localparam op_code_t op_jump_beq  = 5'h01;
    localparam op_code_t op_jump_bne  = 5'h02;
    localparam op_code_t op_jump_blt  = 5'h03;
    localparam op_code_t op_jump_bge  = 5'h04;
    localparam op_code_t op_jump_bltu = 5'h05;
    localparam op_code_t op_jump_bgeu = 5'h06;
    localparam op_code_t op_jump_jal  = 5'h07;
    localparam op_code_t op_jump_jalr = 5'h08;

    localparam imm_sel_t imm_i = 3'd1;
    localparam imm_sel_t imm_s = 3'd2;
    localparam imm_sel_t imm_b = 3'd3;
    localparam imm_sel_t imm_u = 3'd4;
    localparam imm_sel_t imm_j = 3'd5;

    localparam wb_sel_t wb_alu  = 3'd0;
    localparam wb_sel_t wb_mem  = 3'd1;
    localparam wb_sel_t wb_jump = 3'd4;

    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the scoreboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_scoreboard_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_scoreboard_ctrl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1

// File: verification/tb_scoreboard_ctrl.sv
`timescale 1ns/100ps

module tb_scoreboard_ctrl import scoreboard_pkg::*; ();

    // tests take about 60 cycles, leave twice that
    localparam int max_cycles = 120;

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] imm;
    logic        alu_done;
    logic        mem_done;
    logic        jump_done;
    logic        is_jump;
    logic        is_en;
    imm_sel_t    imm_sel;
    logic        alu_en;
    logic        mem_en;
    logic        jump_en;
    reg_idx_t    rs1_ctrl;
    reg_idx_t    rs2_ctrl;
    logic [31:0] pc_ctrl;
    logic [31:0] imm_ctrl;
    op_code_t    jump_op;
    alu_op_t     alu_op;
    logic        alu_use_pc;
    logic        alu_use_imm;
    logic        mem_we;
    mem_bhw_t    mem_bhw;
    wb_sel_t     write_sel;
    logic        reg_write;
    reg_idx_t    rd_ctrl;

    int          error_count = 0;
    int          check_count = 0;
    int          cycles;
    string       test_name = "none";
    logic [31:0] lfsr_state = 32'hd9dc_1c9c;

    scoreboard_ctrl #(
        .xlen(32)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles in test %s", max_cycles, test_name);
        $display("TESTS FAILED");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) lfsr_state = lfsr_state ^ 32'ha300_0000;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic reg_idx_t pick_reg(input reg_idx_t excl);
        logic [31:0] t;
        t = rand_bits(5);
        while (t[4:0] == 5'd0 || t[4:0] == excl) begin  // x0 never a real target
            t = rand_bits(5);
        end
        return t[4:0];
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] sext13(input logic [12:0] v);
        return {{19{v[12]}}, v};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] im, input reg_idx_t rs1,
                                          input logic [2:0] f3, input reg_idx_t rd,
                                          input logic [6:0] opc);
        return {im, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] im, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3);
        return {im[11:5], rs2, rs1, f3, im[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] im, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3);
        return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_r(input reg_idx_t rs2, input reg_idx_t rs1,
                                          input reg_idx_t rd);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};  // add
    endfunction

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("Mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // holds the word for one edge, then returns to an empty slot
    task automatic issue_one(input logic [31:0] word, input logic [31:0] imm_val,
                             input logic [31:0] pc_val, input logic exp_en,
                             input imm_sel_t exp_sel);
        @(negedge clk);
        inst = word;
        imm  = imm_val;
        pc   = pc_val;
        #1;
        check_bit("is_en", exp_en, is_en);
        check_eq("imm_sel", 32'(exp_sel), 32'(imm_sel));
        @(negedge clk);
        inst = '0;
    endtask

    task automatic finish_unit(input fu_id_t unit, input logic exp_write,
                               input reg_idx_t exp_rd, input wb_sel_t exp_sel);
        @(negedge clk);
        alu_done = (unit == fu_alu);
        mem_done = (unit == fu_mem);
        @(negedge clk);
        alu_done = 1'b0;
        mem_done = 1'b0;
        check_bit("reg_write", exp_write, reg_write);
        check_eq("write_sel", 32'(exp_sel), 32'(write_sel));
        if (exp_write) check_eq("rd_ctrl", 32'(exp_rd), 32'(rd_ctrl));
        @(negedge clk);
        check_bit("reg_write one cycle", 1'b0, reg_write);
    endtask

    task automatic wait_mem_en(input int limit);
        int n;
        n = 0;
        while (!mem_en && n < limit) begin
            @(negedge clk);
            n++;
        end
        check_count++;
        assert (mem_en) else begin
            error_count++;
            $display("%s: mem_en did not rise within %0d cycles", test_name, limit);
        end
    endtask

    task automatic test_reset();
        test_name = "reset";
        @(negedge clk);
        check_bit("alu_en", 1'b0, alu_en);
        check_bit("mem_en", 1'b0, mem_en);
        check_bit("jump_en", 1'b0, jump_en);
        check_bit("reg_write", 1'b0, reg_write);
        check_bit("is_en", 1'b1, is_en);
    endtask

    task automatic test_alu();
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [31:0] t;
        logic [31:0] imm_val;
        logic [31:0] pc_val;
        test_name = "alu addi";
        rd      = pick_reg(5'd0);
        rs1     = pick_reg(5'd0);
        t       = rand_bits(12);
        imm_val = sext12(t[11:0]);
        pc_val  = rand_bits(32);
        issue_one(enc_i(t[11:0], rs1, 3'b000, rd, 7'b0010011), imm_val, pc_val, 1'b1, imm_i);
        check_bit("alu_en", 1'b1, alu_en);
        check_bit("alu_use_imm", 1'b1, alu_use_imm);
        check_bit("alu_use_pc", 1'b0, alu_use_pc);
        check_eq("alu_op", 32'(op_alu_add[3:0]), 32'(alu_op));
        check_eq("imm_ctrl", imm_val, imm_ctrl);
        check_eq("rs1_ctrl", 32'(rs1), 32'(rs1_ctrl));
        check_eq("rs2_ctrl", 32'd0, 32'(rs2_ctrl));  // i-type has no rs2
        finish_unit(fu_alu, 1'b1, rd, wb_alu);

        test_name = "alu auipc";
        rd      = pick_reg(5'd0);
        t       = rand_bits(20);
        imm_val = {t[19:0], 12'h000};
        pc_val  = rand_bits(32);
        issue_one({t[19:0], rd, 7'b0010111}, imm_val, pc_val, 1'b1, imm_u);
        check_bit("alu_en", 1'b1, alu_en);
        check_bit("alu_use_pc", 1'b1, alu_use_pc);
        check_eq("alu_op", 32'(op_alu_add[3:0]), 32'(alu_op));
        check_eq("pc_ctrl", pc_val, pc_ctrl);
        check_eq("imm_ctrl", imm_val, imm_ctrl);
        finish_unit(fu_alu, 1'b1, rd, wb_alu);
    endtask

    task automatic test_mem();
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [31:0] t;
        test_name = "mem lw";
        rd  = pick_reg(5'd0);
        rs1 = pick_reg(5'd0);
        t   = rand_bits(12);
        issue_one(enc_i(t[11:0], rs1, 3'b010, rd, 7'b0000011), sext12(t[11:0]), 32'h100,
                  1'b1, imm_i);
        check_bit("mem_en", 1'b1, mem_en);
        check_bit("mem_we", 1'b0, mem_we);
        check_eq("mem_bhw", 32'd2, 32'(mem_bhw));  // word
        check_eq("rs1_ctrl", 32'(rs1), 32'(rs1_ctrl));
        check_eq("imm_ctrl", sext12(t[11:0]), imm_ctrl);
        finish_unit(fu_mem, 1'b1, rd, wb_mem);

        test_name = "mem sb";
        rs1 = pick_reg(5'd0);
        rs2 = pick_reg(rs1);
        t   = rand_bits(12);
        issue_one(enc_s(t[11:0], rs2, rs1, 3'b000), sext12(t[11:0]), 32'h104, 1'b1, imm_s);
        check_bit("mem_en", 1'b1, mem_en);
        check_bit("mem_we", 1'b1, mem_we);
        check_eq("mem_bhw", 32'd0, 32'(mem_bhw));  // byte
        check_eq("rs2_ctrl", 32'(rs2), 32'(rs2_ctrl));
        finish_unit(fu_mem, 1'b0, 5'd0, wb_mem);  // store writes no register
    endtask

    task automatic test_hazards();
        reg_idx_t a;
        reg_idx_t b;
        reg_idx_t s;
        test_name = "hazards";
        a = pick_reg(5'd0);
        b = pick_reg(a);
        s = pick_reg(a);
        issue_one(enc_i(12'h010, s, 3'b000, a, 7'b0010011), 32'h10, 32'h200, 1'b1, imm_i);
        check_bit("alu_en", 1'b1, alu_en);
        issue_one(enc_r(s, s, b), 32'h0, 32'h204, 1'b0, 3'd0);  // alu still busy
        issue_one(enc_i(12'h0, s, 3'b010, a, 7'b0000011), 32'h0, 32'h208, 1'b0, imm_i);  // waw
        issue_one(enc_i(12'h0, a, 3'b010, b, 7'b0000011), 32'h0, 32'h208, 1'b1, imm_i);
        check_bit("mem_en before alu write-back", 1'b0, mem_en);
        finish_unit(fu_alu, 1'b1, a, wb_alu);
        wait_mem_en(8);
        check_eq("rs1_ctrl", 32'(a), 32'(rs1_ctrl));
        finish_unit(fu_mem, 1'b1, b, wb_mem);
    endtask

    task automatic test_jump();
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;
        logic [31:0] t;
        logic [31:0] pc_val;
        logic [31:0] addi;
        test_name = "jump";
        rs1    = pick_reg(5'd0);
        rs2    = pick_reg(5'd0);
        rd     = pick_reg(5'd0);
        t      = rand_bits(12);
        pc_val = rand_bits(32);
        issue_one(enc_b({t[11:0], 1'b0}, rs2, rs1, 3'b000), sext13({t[11:0], 1'b0}), pc_val,
                  1'b1, imm_b);
        check_bit("jump_en", 1'b1, jump_en);
        check_eq("jump_op", 32'(op_jump_beq), 32'(jump_op));
        check_eq("rs1_ctrl", 32'(rs1), 32'(rs1_ctrl));
        check_eq("rs2_ctrl", 32'(rs2), 32'(rs2_ctrl));
        check_eq("pc_ctrl", pc_val, pc_ctrl);
        addi = enc_i(12'h001, 5'd0, 3'b000, rd, 7'b0010011);
        issue_one(addi, 32'h1, pc_val + 32'd4, 1'b0, imm_i);  // held behind the branch
        issue_one(addi, 32'h1, pc_val + 32'd4, 1'b0, imm_i);
        @(negedge clk);
        jump_done = 1'b1;
        is_jump   = 1'b1;
        @(negedge clk);
        jump_done = 1'b0;
        is_jump   = 1'b0;
        inst      = addi;  // lands in the flush slot
        #1;
        check_bit("is_en in flush", 1'b1, is_en);
        check_bit("reg_write for branch", 1'b0, reg_write);
        check_eq("write_sel", 32'(wb_jump), 32'(write_sel));
        @(negedge clk);
        inst = '0;
        check_bit("alu_en after flush", 1'b0, alu_en);
        issue_one(addi, 32'h1, pc_val + 32'd8, 1'b1, imm_i);
        check_bit("alu_en", 1'b1, alu_en);
        finish_unit(fu_alu, 1'b1, rd, wb_alu);
    endtask

    task automatic test_priority();
        reg_idx_t a;
        reg_idx_t b;
        int       n;
        test_name = "priority";
        a = pick_reg(5'd0);
        b = pick_reg(a);
        issue_one(enc_i(12'h004, pick_reg(a), 3'b000, a, 7'b0010011), 32'h4, 32'h300,
                  1'b1, imm_i);
        check_bit("alu_en", 1'b1, alu_en);
        issue_one(enc_i(12'h008, pick_reg(a), 3'b010, b, 7'b0000011), 32'h8, 32'h304,
                  1'b1, imm_i);
        check_bit("mem_en", 1'b1, mem_en);
        @(negedge clk);
        alu_done = 1'b1;
        mem_done = 1'b1;
        @(negedge clk);
        alu_done = 1'b0;
        mem_done = 1'b0;
        check_bit("alu reg_write", 1'b1, reg_write);
        check_eq("alu rd_ctrl", 32'(a), 32'(rd_ctrl));
        check_eq("alu write_sel", 32'(wb_alu), 32'(write_sel));
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!reg_write && n < 8);
        check_bit("mem reg_write", 1'b1, reg_write);
        check_eq("mem rd_ctrl", 32'(b), 32'(rd_ctrl));
        check_eq("mem write_sel", 32'(wb_mem), 32'(write_sel));
        check_eq("mem write-back delay", 32'd1, n);
    endtask

    initial begin
        rst       = 1'b1;
        inst      = '0;
        imm       = '0;
        pc        = '0;
        alu_done  = 1'b0;
        mem_done  = 1'b0;
        jump_done = 1'b0;
        is_jump   = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_alu();
        test_mem();
        test_hazards();
        test_jump();
        test_priority();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/scoreboard_pkg.sv
design/inst_decoder.sv
design/fu_status_table.sv
design/grant_arbiter.sv
design/scoreboard_ctrl.sv
verification/tb_scoreboard_ctrl.sv
